/* core_params.svh */
// Core width and data RAM size macros
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of a data word and of a byte address
`define CORE_XLEN 32

// Data RAM depth in words
`define RAM_WORDS 256

// Bits of the RAM word index
`define RAM_ADDR_BITS 8

`endif

/* core_pkg.sv */
// core_pkg: word and register types, operation and state enums, stream and bus channel structs
`include "core_params.svh"

package core_pkg;

    // Plain vectors with a meaning
    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [`CORE_XLEN-1:0]   addr_t;
    typedef logic [`CORE_XLEN/8-1:0] strb_t;
    typedef logic [4:0]              reg_t;

    // Memory stage operations
    typedef enum logic [3:0] {
        OP_NONE            = 4'd0,
        LOAD_BYTE          = 4'd1,
        LOAD_HALF          = 4'd2,
        LOAD_WORD          = 4'd3,
        LOAD_BYTE_UNSIGNED = 4'd4,
        LOAD_HALF_UNSIGNED = 4'd5,
        STORE_BYTE         = 4'd6,
        STORE_HALF         = 4'd7,
        STORE_WORD         = 4'd8
    } op_t;

    // Token from execute
    typedef struct packed {
        op_t   op;
        addr_t alu;
        word_t rs2;
        reg_t  rd;
    } mm_t;

    // Token toward writeback
    typedef struct packed {
        op_t   op;
        reg_t  rd;
        word_t data;
    } wb_t;

    // AXI4-Lite style channel payloads
    typedef struct packed {
        addr_t addr;
    } axil_aw_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        addr_t addr;
    } axil_ar_t;

    typedef struct packed {
        word_t data;
    } axil_r_t;

    // Memory stage FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STORE,
        ST_LOAD,
        ST_DONE
    } stage_state_t;

endpackage

/* lsu_align.sv */
// lsu_align: store lane placement and strobes, load extraction with sign or zero extension
`timescale 1ns/1ps

module lsu_align
    import core_pkg::*;
(
    input  op_t   op,
    input  addr_t addr,
    input  word_t store_in,
    input  word_t load_in,
    output word_t store_data,
    output strb_t store_strb,
    output word_t load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Store side, register value moved into its byte lanes
    always_comb begin
        case (op)
            STORE_BYTE: begin
                store_data = store_in << (8 * addr[1:0]);
                store_strb = strb_t'(1) << addr[1:0];
            end
            STORE_HALF: begin
                store_data = store_in << {addr[1], 4'b0000};
                store_strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            STORE_WORD: begin
                store_data = store_in;
                store_strb = 4'b1111;
            end
            default: begin
                store_data = '0;
                store_strb = '0;
            end
        endcase
    end

    // Addressed byte and half of the returned word
    always_comb begin
        case (addr[1:0])
            2'b00:   load_byte = load_in[7:0];
            2'b01:   load_byte = load_in[15:8];
            2'b10:   load_byte = load_in[23:16];
            default: load_byte = load_in[31:24];
        endcase
        load_half = addr[1] ? load_in[31:16] : load_in[15:0];
    end

    // Extension by load kind
    always_comb begin
        case (op)
            LOAD_BYTE: begin
                load_data = {{24{load_byte[7]}}, load_byte};
            end
            LOAD_BYTE_UNSIGNED: begin
                load_data = {24'h000000, load_byte};
            end
            LOAD_HALF: begin
                load_data = {{16{load_half[15]}}, load_half};
            end
            LOAD_HALF_UNSIGNED: begin
                load_data = {16'h0000, load_half};
            end
            LOAD_WORD: begin
                load_data = load_in;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

/* memory_stage.sv */
// memory_stage: token FSM driving the AXI4-Lite style memory port and the writeback stream
`timescale 1ns/1ps

module memory_stage
    import core_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,

    input  logic     source_valid,
    output logic     source_ready,
    input  mm_t      source_data,

    output logic     sink_valid,
    input  logic     sink_ready,
    output wb_t      sink_data,

    output logic     aw_valid,
    output axil_aw_t aw,
    input  logic     aw_ready,

    output logic     w_valid,
    output axil_w_t  w,
    input  logic     w_ready,

    input  logic     b_valid,
    output logic     b_ready,

    output logic     ar_valid,
    output axil_ar_t ar,
    input  logic     ar_ready,

    input  logic     r_valid,
    input  axil_r_t  r,
    output logic     r_ready
);

    stage_state_t state;
    mm_t          tok;
    word_t        wb_data;
    logic         resp_seen;
    logic         accept;
    word_t        store_data;
    strb_t        store_strb;
    word_t        load_data;

    function automatic logic is_store(input op_t op);
        return op inside {STORE_BYTE, STORE_HALF, STORE_WORD};
    endfunction

    function automatic logic is_load(input op_t op);
        return op inside {LOAD_BYTE, LOAD_HALF, LOAD_WORD,
                          LOAD_BYTE_UNSIGNED, LOAD_HALF_UNSIGNED};
    endfunction

    // Alignment works on the held token
    lsu_align align_i (
        .op         (tok.op),
        .addr       (tok.alu),
        .store_in   (tok.rs2),
        .load_in    (r.data),
        .store_data (store_data),
        .store_strb (store_strb),
        .load_data  (load_data)
    );

    assign source_ready = (state == ST_IDLE);
    assign accept       = source_valid && source_ready;

    assign b_ready = (state == ST_STORE);
    assign r_ready = (state == ST_LOAD);

    // Request payloads stay stable while the token is held
    assign aw.addr = tok.alu;
    assign w.data  = store_data;
    assign w.strb  = store_strb;
    assign ar.addr = tok.alu;

    assign sink_data.op   = tok.op;
    assign sink_data.rd   = tok.rd;
    assign sink_data.data = wb_data;

    always_ff @(posedge aclk) begin
        if (accept) begin
            tok <= source_data;
        end
    end

    // Writeback value
    always_ff @(posedge aclk) begin
        if (accept) begin
            if (is_store(source_data.op)) begin
                wb_data <= '0;
            end else begin
                wb_data <= source_data.alu;
            end
        end else if (r_valid && r_ready) begin
            wb_data <= load_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= ST_IDLE;
            sink_valid <= 1'b0;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            ar_valid   <= 1'b0;
            resp_seen  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (source_valid) begin
                        if (is_store(source_data.op)) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= ST_STORE;
                        end else if (is_load(source_data.op)) begin
                            ar_valid <= 1'b1;
                            state    <= ST_LOAD;
                        end else begin
                            sink_valid <= 1'b1;
                            state      <= ST_DONE;
                        end
                    end
                end
                ST_STORE: begin
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_valid && w_ready) begin
                        w_valid <= 1'b0;
                    end
                    // Token goes out one edge after the write response
                    if (resp_seen) begin
                        resp_seen  <= 1'b0;
                        sink_valid <= 1'b1;
                        state      <= ST_DONE;
                    end else if (b_valid && b_ready) begin
                        resp_seen <= 1'b1;
                    end
                end
                ST_LOAD: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (r_valid && r_ready) begin
                        sink_valid <= 1'b1;
                        state      <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (sink_ready) begin
                        sink_valid <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* data_ram.sv */
// data_ram: byte-strobed word RAM behind AXI4-Lite style write and read channels
`timescale 1ns/1ps
`include "core_params.svh"

module data_ram
    import core_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,

    input  logic     aw_valid,
    input  axil_aw_t aw,
    output logic     aw_ready,

    input  logic     w_valid,
    input  axil_w_t  w,
    output logic     w_ready,

    output logic     b_valid,
    input  logic     b_ready,

    input  logic     ar_valid,
    input  axil_ar_t ar,
    output logic     ar_ready,

    output logic     r_valid,
    output axil_r_t  r,
    input  logic     r_ready
);

    word_t                     mem [`RAM_WORDS];
    logic [`RAM_ADDR_BITS-1:0] wr_index;
    logic [`RAM_ADDR_BITS-1:0] rd_index;
    logic                      wr_fire;

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign wr_index = aw.addr[`RAM_ADDR_BITS+1:2];
    assign rd_index = ar.addr[`RAM_ADDR_BITS+1:2];

    // Address and data taken together, only with no response pending
    assign aw_ready = aw_valid && w_valid && !b_valid;
    assign w_ready  = aw_ready;
    assign wr_fire  = aw_valid && aw_ready;

    assign ar_ready = !r_valid;

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            for (int lane = 0; lane < $bits(strb_t); lane++) begin
                if (w.strb[lane]) begin
                    mem[wr_index][8*lane +: 8] <= w.data[8*lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_valid && ar_ready) begin
            r.data <= mem[rd_index];
        end
    end

    // Response valids
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

endmodule

/* mem_subsystem.sv */
// mem_subsystem: memory stage joined to the data RAM
`timescale 1ns/1ps

module mem_subsystem
    import core_pkg::*;
(
    input  logic aclk,
    input  logic aresetn,

    input  logic source_valid,
    output logic source_ready,
    input  mm_t  source_data,

    output logic sink_valid,
    input  logic sink_ready,
    output wb_t  sink_data
);

    // Memory port
    logic     aw_valid;
    axil_aw_t aw;
    logic     aw_ready;
    logic     w_valid;
    axil_w_t  w;
    logic     w_ready;
    logic     b_valid;
    logic     b_ready;
    logic     ar_valid;
    axil_ar_t ar;
    logic     ar_ready;
    logic     r_valid;
    axil_r_t  r;
    logic     r_ready;

    memory_stage stage_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .source_valid (source_valid),
        .source_ready (source_ready),
        .source_data  (source_data),
        .sink_valid   (sink_valid),
        .sink_ready   (sink_ready),
        .sink_data    (sink_data),
        .aw_valid     (aw_valid),
        .aw           (aw),
        .aw_ready     (aw_ready),
        .w_valid      (w_valid),
        .w            (w),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .ar_valid     (ar_valid),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .r_ready      (r_ready)
    );

    data_ram ram_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .aw_valid (aw_valid),
        .aw       (aw),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w        (w),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready)
    );

endmodule

/* tb_mem_subsystem.sv */
// tb_mem_subsystem: file-driven testbench for the memory stage and data RAM
`timescale 1ns/1ps

module tb_mem_subsystem;
    import core_pkg::*;

    // Six hex columns per token in the stimulus file
    localparam int COLS             = 6;
    localparam int MAX_TOKENS       = 64;
    localparam int CYCLES_PER_TOKEN = 20;

    logic aclk;
    logic aresetn;
    logic source_valid;
    logic source_ready;
    mm_t  source_data;
    logic sink_valid;
    logic sink_ready;
    wb_t  sink_data;

    logic [31:0] stim [MAX_TOKENS*COLS];
    logic [31:0] lfsr;
    logic        holding;
    int          num_tokens;
    int          checked;
    int          error_count;
    int          group_errors;
    int          group_tokens;
    int          groups_passed;
    int          groups_failed;
    int          cycle_count;
    int          cycle_limit;

    mem_subsystem dut_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .source_valid (source_valid),
        .source_ready (source_ready),
        .source_data  (source_data),
        .sink_valid   (sink_valid),
        .sink_ready   (sink_ready),
        .sink_data    (sink_data)
    );

    always #20 aclk = ~aclk;

    // Galois form with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] stim_field(input int idx, input int col);
        return stim[idx*COLS + col];
    endfunction

    function automatic string group_name(input logic [31:0] grp);
        case (grp)
            1:       return "pass-through";
            2:       return "word store and load";
            3:       return "byte lanes";
            4:       return "half lanes";
            5:       return "mixed with back-pressure";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
            group_errors++;
        end
    endtask

    task automatic load_stimulus();
        for (int i = 0; i < MAX_TOKENS*COLS; i++) begin
            stim[i] = 'x;
        end
        $readmemh("mem_stim.txt", stim);
        num_tokens = 0;
        while (num_tokens < MAX_TOKENS && !$isunknown(stim[num_tokens*COLS])) begin
            num_tokens++;
        end
    endtask

    task automatic drive_token(input int idx);
        logic [31:0] op_word;
        logic [31:0] rd_word;
        op_word = stim_field(idx, 1);
        rd_word = stim_field(idx, 4);
        source_data.op  = op_t'(op_word[3:0]);
        source_data.alu = stim_field(idx, 2);
        source_data.rs2 = stim_field(idx, 3);
        source_data.rd  = rd_word[4:0];
        source_valid    = 1'b1;
    endtask

    task automatic finish_group(input logic [31:0] grp);
        if (group_errors == 0) begin
            $display("Group %0d %s: ok, %0d tokens", grp, group_name(grp), group_tokens);
            groups_passed++;
        end else begin
            $display("Group %0d %s: FAIL, %0d mismatches in %0d tokens",
                     grp, group_name(grp), group_errors, group_tokens);
            groups_failed++;
        end
        group_errors = 0;
        group_tokens = 0;
    endtask

    // Random sink back-pressure from one LFSR bit per cycle
    always @(posedge aclk) begin
        #1;
        sink_ready = lfsr[0];
        lfsr = lfsr_next(lfsr);
    end

    // Sink transfers seen mid-cycle complete at the next rising edge
    always @(negedge aclk) begin
        if (aresetn) begin
            // Stage takes a new token only while it holds none
            check_value("source_ready", {31'd0, source_ready}, {31'd0, !holding});
            if (source_valid && source_ready) begin
                holding = 1'b1;
            end
            if (sink_valid && sink_ready) begin
                holding = 1'b0;
                if (checked >= num_tokens) begin
                    $display("Extra writeback token at %0t ns after all %0d tokens were seen",
                             $time, num_tokens);
                    error_count++;
                end else begin
                    check_value($sformatf("token %0d op", checked),
                                {28'd0, sink_data.op}, stim_field(checked, 1));
                    check_value($sformatf("token %0d rd", checked),
                                {27'd0, sink_data.rd}, stim_field(checked, 4));
                    check_value($sformatf("token %0d data", checked),
                                sink_data.data, stim_field(checked, 5));
                    group_tokens++;
                    checked++;
                    if (checked == num_tokens ||
                        stim_field(checked, 0) != stim_field(checked - 1, 0)) begin
                        finish_group(stim_field(checked - 1, 0));
                    end
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles with %0d of %0d tokens written back",
                     cycle_count, checked, num_tokens);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        aclk          = 1'b0;
        aresetn       = 1'b0;
        source_valid  = 1'b0;
        source_data   = '0;
        sink_ready    = 1'b0;
        lfsr          = 32'h461b_7aef;
        holding       = 1'b0;
        checked       = 0;
        error_count   = 0;
        group_errors  = 0;
        group_tokens  = 0;
        groups_passed = 0;
        groups_failed = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        load_stimulus();
        if (num_tokens == 0) begin
            $display("No tokens could be read from mem_stim.txt, so nothing was checked");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = num_tokens * CYCLES_PER_TOKEN;
            repeat (2) @(posedge aclk);
            #1;
            aresetn = 1'b1;
            for (int i = 0; i < num_tokens; i++) begin
                drive_token(i);
                // Accepted at the edge after a cycle with ready high
                @(negedge aclk);
                while (!source_ready) begin
                    @(negedge aclk);
                end
                @(posedge aclk);
                #1;
            end
            source_valid = 1'b0;
            source_data  = '0;
            wait (checked == num_tokens);
            // Extra cycles to catch a repeated token
            repeat (8) @(posedge aclk);
            $display("Groups passed: %0d, groups failed: %0d, mismatches: %0d",
                     groups_passed, groups_failed, error_count);
            if (error_count == 0 && groups_failed == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

/* mem_stim.txt */
// Columns: group, op code, alu or address, rs2, rd, expected writeback data (hex)
// Op codes: 0 none, 1 lb, 2 lh, 3 lw, 4 lbu, 5 lhu, 6 sb, 7 sh, 8 sw
1 0 12345678 ffffffff 01 12345678
1 0 00000000 00000000 02 00000000
1 0 80000001 13579bdf 1f 80000001
2 8 00000010 deadbeef 00 00000000
2 3 00000010 00000000 05 deadbeef
2 8 000003fc 0badf00d 07 00000000
2 3 000003fc 00000000 06 0badf00d
3 8 00000020 11223344 00 00000000
3 6 00000020 deadbef0 00 00000000
3 6 00000021 0000007f 00 00000000
3 3 00000020 00000000 08 11227ff0
3 6 00000022 12345699 00 00000000
3 6 00000023 abcdef80 00 00000000
3 3 00000020 00000000 09 80997ff0
3 1 00000020 00000000 0a fffffff0
3 4 00000020 00000000 0b 000000f0
3 1 00000021 00000000 0c 0000007f
3 4 00000021 00000000 0d 0000007f
3 1 00000022 00000000 0e ffffff99
3 4 00000022 00000000 0f 00000099
3 1 00000023 00000000 10 ffffff80
3 4 00000023 00000000 11 00000080
4 7 00000030 ffff8001 00 00000000
4 7 00000032 55557abc 00 00000000
4 2 00000030 00000000 12 ffff8001
4 5 00000030 00000000 13 00008001
4 2 00000032 00000000 14 00007abc
4 5 00000032 00000000 15 00007abc
5 0 55aa55aa 00000000 03 55aa55aa
5 8 00000040 cafe1234 00 00000000
5 4 00000043 00000000 16 000000ca
5 2 00000042 00000000 17 ffffcafe
5 6 00000041 0000005a 00 00000000
5 3 00000040 00000000 18 cafe5a34
5 7 00000046 dead8888 00 00000000
5 5 00000046 00000000 19 00008888
5 0 ffffffff 00000000 1f ffffffff

/* files.f */
+incdir+.
core_pkg.sv
lsu_align.sv
memory_stage.sv
data_ram.sv
mem_subsystem.sv
tb_mem_subsystem.sv
